// File: design/rfid_consts.svh
`ifndef RFID_CONSTS_SVH
`define RFID_CONSTS_SVH

// ns to clock counts, 128 ns per count
`define RFID_CLK_EXP 7

// fixed reader pulse lengths in ns
`define RFID_DELIM_NS 15000
`define RFID_PW_NS    1000

// frame and reply buffers
`define RFID_FRAME_BITS 128
`define RFID_RX_BITS    128

// cycles with no backscatter edge before giving up
`define RFID_RX_TIMEOUT_CNT 4096

`endif

// File: design/rfid_cmd_pkg.sv
`include "rfid_consts.svh"

package rfid_cmd_pkg;

    // numbering follows the full Gen2 command table, gaps are unsupported commands
    typedef enum logic [3:0] {
        CMD_QUERYREP = 4'd0,
        CMD_ACK      = 4'd1,
        CMD_QUERY    = 4'd2,
        CMD_QUERYADJ = 4'd3,
        CMD_NACK     = 4'd5,
        CMD_REQRN    = 4'd6,
        CMD_READ     = 4'd7
    } reader_cmd_e;

    typedef struct packed {
        logic [3:0] slot_q;
        logic [2:0] q_adj;   // Q up/down code
        logic [1:0] session;
        logic [1:0] select;
        logic       target;
    } inv_cfg_t;

    // data is right aligned, sent msb of the used part first
    typedef struct packed {
        logic [6:0]                   length;
        logic [`RFID_FRAME_BITS-1:0] data;
    } tx_frame_t;

endpackage

// File: design/rfid_link_pkg.sv
package rfid_link_pkg;

    typedef struct packed {
        logic [2:0]  miller;
        logic        trext;
        logic        divide_ratio;
        logic [15:0] tari_ns;
        logic [15:0] trcal_ns;
    } link_cfg_t;

    // all in clock counts, pw already taken out of the high phases
    typedef struct packed {
        logic [15:0] delim;
        logic [15:0] pw;
        logic [15:0] tari;
        logic [15:0] rtcal;
        logic [15:0] trcal;
    } link_timing_t;

    typedef enum logic [2:0] {
        IDLE,
        DELIM,
        DATA0,
        RTCAL,
        TRCAL,
        BITS,
        DONE
    } pie_state_e;

    typedef enum logic [1:0] {
        WAIT_EDGE,
        SAMPLE,
        TIMEOUT
    } fm0_state_e;

endpackage

// File: design/rfid_pie_encoder.sv
module rfid_pie_encoder
    import rfid_cmd_pkg::*;
    import rfid_link_pkg::*;
(
    input  logic         clk,
    input  logic         reset,
    input  logic         tx_go,
    input  logic         send_trcal,
    input  tx_frame_t    frame,
    input  link_timing_t timing,
    output logic         reader_modulation,
    output logic         tx_done,
    output logic         tx_running
);

    pie_state_e  state;
    tx_frame_t   frame_q;
    logic        trcal_q;
    logic        low_phase;  // in the pw part of a symbol
    logic [15:0] cnt;
    logic [6:0]  bit_idx;
    logic [6:0]  next_idx;

    assign next_idx   = bit_idx - 7'd1;
    assign tx_done    = (state == DONE);
    assign tx_running = (state != IDLE);

    // high phase length minus one for a data symbol
    function automatic logic [15:0] bit_high(input logic b, input link_timing_t t);
        if (b) begin
            return (t.tari << 1) + t.pw - 16'd1;
        end
        return t.tari - 16'd1;
    endfunction

    always_ff @(posedge clk) begin
        if (tx_go) begin
            frame_q <= frame;
            trcal_q <= send_trcal;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state             <= IDLE;
            low_phase         <= 1'b0;
            cnt               <= 16'd0;
            bit_idx           <= 7'd0;
            reader_modulation <= 1'b1;
        end else begin
            case (state)
                IDLE: begin
                    reader_modulation <= 1'b1;
                    if (tx_go) begin
                        state             <= DELIM;
                        cnt               <= timing.delim - 16'd1;
                        bit_idx           <= frame.length - 7'd1;
                        reader_modulation <= 1'b0;
                    end
                end
                DELIM: begin
                    if (cnt != 16'd0) begin
                        cnt <= cnt - 16'd1;
                    end else begin
                        state             <= DATA0;
                        cnt               <= timing.tari - 16'd1;
                        reader_modulation <= 1'b1;
                    end
                end
                DONE: begin
                    state <= IDLE;
                end
                default: begin
                    // DATA0, RTCAL, TRCAL and BITS: high phase then pw low
                    if (cnt != 16'd0) begin
                        cnt <= cnt - 16'd1;
                    end else if (!low_phase) begin
                        low_phase         <= 1'b1;
                        cnt               <= timing.pw - 16'd1;
                        reader_modulation <= 1'b0;
                    end else begin
                        low_phase         <= 1'b0;
                        reader_modulation <= 1'b1;
                        case (state)
                            DATA0: begin
                                state <= RTCAL;
                                cnt   <= timing.rtcal - 16'd1;
                            end
                            RTCAL: begin
                                if (trcal_q) begin
                                    state <= TRCAL;
                                    cnt   <= timing.trcal - 16'd1;
                                end else begin
                                    state <= BITS;
                                    cnt   <= bit_high(frame_q.data[bit_idx], timing);
                                end
                            end
                            TRCAL: begin
                                state <= BITS;
                                cnt   <= bit_high(frame_q.data[bit_idx], timing);
                            end
                            default: begin
                                if (bit_idx == 7'd0) begin
                                    state <= DONE;  // last symbol over
                                end else begin
                                    bit_idx <= next_idx;
                                    cnt     <= bit_high(frame_q.data[next_idx], timing);
                                end
                            end
                        endcase
                    end
                end
            endcase
        end
    end

    // controller only starts a frame once the previous one has ended
    a_no_go_while_busy: assert property (
        @(posedge clk) disable iff (reset) tx_go |-> !tx_running
    ) else $error("tx_go while encoder running");

endmodule

// File: design/rfid_fm0_decoder.sv
`include "rfid_consts.svh"

module rfid_fm0_decoder
    import rfid_link_pkg::*;
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     rx_enable,
    input  logic                     tag_backscatter,
    input  link_timing_t             timing,
    output logic [`RFID_RX_BITS-1:0] rx_data,
    output logic [7:0]               rx_count,
    output logic                     rx_timeout
);

    fm0_state_e  state;
    logic [1:0]  bs_sync;
    logic        bs_prev;
    logic        bs_edge;
    logic        en_q;
    logic        en_rise;
    logic [15:0] half;
    logic [15:0] quarter;
    logic [15:0] bit_cnt;   // cycles since the bit boundary
    logic [15:0] wait_cnt;
    logic        first_lvl; // level at the quarter point
    logic        shift_en;

    assign half       = timing.trcal >> 4;  // divide ratio 8 only
    assign quarter    = half >> 1;
    assign bs_edge    = bs_sync[1] ^ bs_prev;
    assign en_rise    = rx_enable & ~en_q;
    assign shift_en   = (state == SAMPLE) && (bit_cnt == half + quarter);
    assign rx_timeout = (state == TIMEOUT);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bs_sync <= 2'b00;
            bs_prev <= 1'b0;
            en_q    <= 1'b0;
        end else begin
            bs_sync <= {bs_sync[0], tag_backscatter};
            bs_prev <= bs_sync[1];
            en_q    <= rx_enable;
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state     <= WAIT_EDGE;
            bit_cnt   <= 16'd0;
            wait_cnt  <= 16'd0;
            first_lvl <= 1'b0;
            rx_count  <= 8'd0;
        end else if (!rx_enable || en_rise) begin
            state    <= WAIT_EDGE;
            wait_cnt <= 16'd0;
            if (en_rise) begin
                rx_count <= 8'd0;
            end
        end else begin
            case (state)
                WAIT_EDGE: begin
                    if (bs_edge) begin
                        state    <= SAMPLE;  // every FM0 bit opens with a transition
                        bit_cnt  <= 16'd1;
                        wait_cnt <= 16'd0;
                    end else if (wait_cnt == `RFID_RX_TIMEOUT_CNT - 1) begin
                        state <= TIMEOUT;
                    end else begin
                        wait_cnt <= wait_cnt + 16'd1;
                    end
                end
                SAMPLE: begin
                    bit_cnt <= bit_cnt + 16'd1;
                    if (bit_cnt == quarter) begin
                        first_lvl <= bs_sync[1];
                    end
                    if (shift_en) begin
                        state    <= WAIT_EDGE;
                        rx_count <= rx_count + 8'd1;
                    end
                end
                default: begin
                    state <= TIMEOUT;  // held until rx_enable drops
                end
            endcase
        end
    end

    // no mid-bit transition means a 1
    always_ff @(posedge clk) begin
        if (en_rise) begin
            rx_data <= '0;
        end else if (rx_enable && shift_en) begin
            rx_data <= {rx_data[`RFID_RX_BITS-2:0], first_lvl == bs_sync[1]};
        end
    end

    // controller must stop the reply before the buffer overruns
    a_count_in_range: assert property (
        @(posedge clk) disable iff (reset) rx_count <= `RFID_RX_BITS
    ) else $error("rx_count beyond buffer");

endmodule

// File: design/rfid_reader_packet_rxtx.sv
`include "rfid_consts.svh"

module rfid_reader_packet_rxtx
    import rfid_cmd_pkg::*;
    import rfid_link_pkg::*;
(
    input  logic        clk,
    input  logic        reset,
    input  logic        start_tx,
    input  reader_cmd_e cmd,
    input  inv_cfg_t    inv,
    input  link_cfg_t   link,
    input  logic [15:0] tx_handle,
    input  logic        tag_backscatter,
    output logic        reader_modulation,
    output logic        reader_done,
    output logic        rx_timeout,
    output logic        rx_packet_complete,
    output logic        reader_running,
    output logic [15:0] rx_handle
);

    typedef enum logic [1:0] {CTL_IDLE, CTL_TX, CTL_RX} ctl_state_e;

    ctl_state_e               state;
    link_timing_t             timing;
    tx_frame_t                frame_q;
    reader_cmd_e              cmd_q;
    logic                     trcal_q;
    logic                     tx_go;
    logic                     tx_done;
    logic                     tx_running;
    logic                     rx_enable;
    logic                     rx_live;  // decoder counters valid again
    logic [`RFID_RX_BITS-1:0] rx_data;
    logic [7:0]               rx_count;
    logic [7:0]               reply_len;
    logic [15:0]              first_word;
    logic                     has_handle;
    logic                     accept;

    function automatic tx_frame_t build_frame(input reader_cmd_e c, input inv_cfg_t i,
                                              input link_cfg_t l, input logic [15:0] h);
        case (c)
            CMD_QUERYREP: return '{length: 7'd4, data: {2'b00, i.session}};
            CMD_ACK:      return '{length: 7'd18, data: {2'b01, h}};
            // Gen2 M field is two bits, crc5 left as zeros
            CMD_QUERY:    return '{length: 7'd22, data: {4'b1000, l.divide_ratio,
                                   l.miller[1:0], l.trext, i.select, i.session,
                                   i.target, i.slot_q, 5'd0}};
            CMD_QUERYADJ: return '{length: 7'd9, data: {4'b1001, i.session, i.q_adj}};
            CMD_NACK:     return '{length: 7'd8, data: 8'b11000000};
            CMD_REQRN:    return '{length: 7'd40, data: {8'b11000001, h, 16'd0}};
            // user bank, word 0, one word
            CMD_READ:     return '{length: 7'd58, data: {8'b11000010, 2'b11, 8'd0,
                                   8'd1, h, 16'd0}};
            default:      return '0;
        endcase
    endfunction

    function automatic logic [7:0] reply_bits(input reader_cmd_e c);
        case (c)
            CMD_QUERYREP, CMD_QUERY, CMD_QUERYADJ: return 8'd16;
            CMD_ACK:   return 8'd112;
            CMD_REQRN: return 8'd32;
            CMD_READ:  return 8'd49;
            default:   return 8'd0;  // nack, no reply
        endcase
    endfunction

    always_comb begin
        timing.delim = 16'(`RFID_DELIM_NS >> `RFID_CLK_EXP);
        timing.pw    = 16'(`RFID_PW_NS >> `RFID_CLK_EXP);
        timing.tari  = (link.tari_ns >> `RFID_CLK_EXP) - timing.pw;
        timing.rtcal = (link.tari_ns >> (`RFID_CLK_EXP - 1)) + timing.tari - timing.pw;
        timing.trcal = (link.trcal_ns >> `RFID_CLK_EXP) - timing.pw;
    end

    assign accept         = start_tx && (state == CTL_IDLE) && !tx_running;
    assign reply_len      = reply_bits(cmd_q);
    assign has_handle     = cmd_q inside {CMD_QUERY, CMD_QUERYREP, CMD_QUERYADJ, CMD_REQRN};
    assign first_word     = 16'(rx_data >> (reply_len - 8'd16));  // first bits sit on top
    assign rx_enable      = (state == CTL_RX);
    assign reader_running = (state != CTL_IDLE);

    always_ff @(posedge clk) begin
        if (accept) begin
            frame_q <= build_frame(cmd, inv, link, tx_handle);
            cmd_q   <= cmd;
            trcal_q <= (cmd == CMD_QUERY);
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state              <= CTL_IDLE;
            tx_go              <= 1'b0;
            rx_live            <= 1'b0;
            reader_done        <= 1'b0;
            rx_packet_complete <= 1'b0;
            rx_handle          <= 16'd0;
        end else begin
            tx_go              <= accept;
            rx_live            <= rx_enable;
            rx_packet_complete <= 1'b0;
            case (state)
                CTL_IDLE: begin
                    if (accept) begin
                        state       <= CTL_TX;
                        reader_done <= 1'b0;
                    end
                end
                CTL_TX: begin
                    if (tx_done) begin
                        if (reply_len == 8'd0) begin
                            state       <= CTL_IDLE;
                            reader_done <= 1'b1;
                        end else begin
                            state <= CTL_RX;
                        end
                    end
                end
                CTL_RX: begin
                    if (rx_live && rx_count >= reply_len) begin
                        state              <= CTL_IDLE;
                        reader_done        <= 1'b1;
                        rx_packet_complete <= 1'b1;
                        if (has_handle) begin
                            rx_handle <= {first_word[7:0], first_word[15:8]};  // byte swap
                        end
                    end else if (rx_timeout) begin
                        state       <= CTL_IDLE;
                        reader_done <= 1'b1;
                    end
                end
                default: begin
                    state <= CTL_IDLE;
                end
            endcase
        end
    end

    rfid_pie_encoder u_tx (
        .clk               (clk),
        .reset             (reset),
        .tx_go             (tx_go),
        .send_trcal        (trcal_q),
        .frame             (frame_q),
        .timing            (timing),
        .reader_modulation (reader_modulation),
        .tx_done           (tx_done),
        .tx_running        (tx_running)
    );

    rfid_fm0_decoder u_rx (
        .clk             (clk),
        .reset           (reset),
        .rx_enable       (rx_enable),
        .tag_backscatter (tag_backscatter),
        .timing          (timing),
        .rx_data         (rx_data),
        .rx_count        (rx_count),
        .rx_timeout      (rx_timeout)
    );

    // a reply either completes or times out
    a_complete_xor_timeout: assert property (
        @(posedge clk) disable iff (reset) !(rx_packet_complete && rx_timeout)
    ) else $error("rx_packet_complete with rx_timeout");

endmodule

// File: tb/rfid_reader_checker.sv
module rfid_reader_checker (
    input  logic         clk,
    input  logic         reset,
    input  logic         start_tx,
    input  logic         reader_modulation,
    input  logic         reader_done,
    input  logic         rx_timeout,
    input  logic         rx_packet_complete,
    input  logic         reader_running,
    input  logic [15:0]  rx_handle,
    input  int           exp_len,
    input  logic [127:0] exp_data,
    input  logic         exp_query,
    input  logic [15:0]  exp_handle,
    input  logic         exp_timeout,
    output int           errors,
    output int           frames
);
    timeunit 1ns;
    timeprecision 100ps;

    logic         reset_checked = 1'b0;
    logic         prev_mod = 1'b1;
    logic         prev_done = 1'b0;
    logic         prev_running = 1'b0;
    logic         in_frame = 1'b0;
    logic         start_seen = 1'b0;
    int           lo_cnt = 0;
    int           hi_cnt = 0;
    int           sym_idx = 0;
    int           h0 = 0;
    int           rtcal_len = 0;
    int           nbits = 0;
    int           complete_cnt = 0;
    logic         trcal_seen = 1'b0;
    logic         timeout_seen = 1'b0;
    logic [127:0] bits = '0;

    initial begin
        errors = 0;
        frames = 0;
    end

    task automatic report_mismatch(input string name, input logic [127:0] exp,
                                   input logic [127:0] got);
        $display("ERR %0t %s expected %0h actual %0h", $time, name, exp, got);
        errors++;
    endtask

    // one finished high phase of the PIE stream
    task automatic classify_high(input int len);
        if (sym_idx == 0) begin
            h0 = len;  // data-0 gives tari
        end else if (sym_idx == 1) begin
            rtcal_len = len;
        end else if (sym_idx == 2 && len > rtcal_len) begin
            trcal_seen = 1'b1;
        end else begin
            bits = {bits[126:0], (len * 2 > h0 * 3)};
            nbits++;
        end
        sym_idx++;
    endtask

    task automatic compare_frame();
        if (nbits != exp_len) report_mismatch("frame_length", exp_len, nbits);
        if (bits != exp_data) report_mismatch("frame_data", exp_data, bits);
        if (trcal_seen != exp_query) report_mismatch("trcal_present", exp_query, trcal_seen);
        frames++;
    endtask

    always @(posedge clk) begin
        if (!reset) begin
            // first edge out of reset still shows the reset values
            if (!reset_checked) begin
                reset_checked = 1'b1;
                if (reader_modulation !== 1'b1)
                    report_mismatch("reader_modulation", 1, reader_modulation);
                if (reader_done !== 1'b0)
                    report_mismatch("reader_done", 0, reader_done);
                if (rx_timeout !== 1'b0)
                    report_mismatch("rx_timeout", 0, rx_timeout);
                if (rx_packet_complete !== 1'b0)
                    report_mismatch("rx_packet_complete", 0, rx_packet_complete);
                if (reader_running !== 1'b0)
                    report_mismatch("reader_running", 0, reader_running);
            end

            // pie decode
            if (!reader_modulation) begin
                if (prev_mod && in_frame) classify_high(hi_cnt);
                hi_cnt = 0;
                lo_cnt++;
            end else begin
                if (!prev_mod && lo_cnt > 50) begin  // delimiter
                    in_frame = 1'b1;
                    sym_idx = 0;
                    nbits = 0;
                    bits = '0;
                    trcal_seen = 1'b0;
                end
                lo_cnt = 0;
                hi_cnt++;
                if (in_frame && hi_cnt > 1000) begin  // idle, frame is over
                    in_frame = 1'b0;
                    compare_frame();
                end
            end
            prev_mod = reader_modulation;

            // running flag
            if (start_seen && !reader_running)
                report_mismatch("reader_running", 1, reader_running);
            start_seen = 1'b0;
            if (reader_running && reader_done)
                report_mismatch("reader_done", 0, reader_done);
            if (start_tx && !reader_running) begin
                start_seen = 1'b1;
                complete_cnt = 0;
                timeout_seen = 1'b0;
            end

            // reply
            if (rx_packet_complete) complete_cnt++;
            if (rx_timeout) timeout_seen = 1'b1;
            if (reader_done && !prev_done) begin
                if (timeout_seen != exp_timeout)
                    report_mismatch("rx_timeout", exp_timeout, timeout_seen);
                if (complete_cnt != ((exp_timeout || exp_len == 8) ? 0 : 1))
                    report_mismatch("rx_packet_complete_count",
                        (exp_timeout || exp_len == 8) ? 0 : 1, complete_cnt);
                if (rx_handle !== exp_handle)
                    report_mismatch("rx_handle", exp_handle, rx_handle);
            end
            prev_done = reader_done;

            // running only ends together with done
            if (prev_running && !reader_running && !reader_done)
                report_mismatch("reader_done", 1, reader_done);
            prev_running = reader_running;
        end
    end
endmodule

// File: tb/rfid_reader_tb.sv
`include "rfid_consts.svh"

module rfid_reader_tb
    import rfid_cmd_pkg::*;
    import rfid_link_pkg::*;
;
    timeunit 1ns;
    timeprecision 100ps;

    logic         clk = 1'b0;
    logic         reset = 1'b1;
    logic         start_tx = 1'b0;
    reader_cmd_e  cmd = CMD_QUERYREP;
    inv_cfg_t     inv = '0;
    link_cfg_t    link = '0;
    logic [15:0]  tx_handle = '0;
    logic         tag_backscatter = 1'b0;
    logic         reader_modulation, reader_done, rx_timeout;
    logic         rx_packet_complete, reader_running;
    logic [15:0]  rx_handle;
    int           exp_len = 0;
    logic [127:0] exp_data = '0;
    logic         exp_query = 1'b0;
    logic [15:0]  exp_handle = '0;
    logic         exp_timeout = 1'b0;
    int           errors, frames;

    // pattern table
    int           p_cmd[16], p_tari[16], p_trcal[16], p_nbits[16], p_len[16], p_to[16];
    logic [127:0] p_inv[16], p_handle[16], p_reply[16], p_data[16], p_exp_h[16];
    int           n_tests = 0;
    int           cycles = 0;
    longint       limit = 0;
    int           seed = 26;

    always #50 clk = ~clk;

    rfid_reader_packet_rxtx dut_i (.*);

    rfid_reader_checker checker_i (.*);

    always @(posedge clk) begin
        cycles++;
        if (limit != 0 && cycles > limit) begin
            $display("run stopped: cycle limit of %0d reached", limit);
            $display("Result: FAILED");
            $finish;
        end
    end

    task automatic read_patterns(output bit opened);
        int    fd;
        int    slot_q, q_adj, session, sel, target;
        int    tari_c, trcal_c;
        string line;
        fd = $fopen("tb/rfid_patterns.txt", "r");
        opened = (fd != 0);
        if (opened) begin
            while (!$feof(fd)) begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() > 5 && line[0] != "#") begin
                    void'($sscanf(line, "%d %d %d %h %h %h %h %h %h %d %h %d %h %h %d",
                        p_cmd[n_tests], p_tari[n_tests], p_trcal[n_tests], slot_q, q_adj,
                        session, sel, target, p_handle[n_tests], p_nbits[n_tests],
                        p_reply[n_tests], p_len[n_tests], p_data[n_tests],
                        p_exp_h[n_tests], p_to[n_tests]));
                    p_inv[n_tests] = {slot_q[3:0], q_adj[2:0], session[1:0], sel[1:0],
                                      target[0]};
                    tari_c = (p_tari[n_tests] >> `RFID_CLK_EXP)
                             - (`RFID_PW_NS >> `RFID_CLK_EXP);
                    trcal_c = (p_trcal[n_tests] >> `RFID_CLK_EXP)
                              - (`RFID_PW_NS >> `RFID_CLK_EXP);
                    limit += p_len[n_tests] * 3 * tari_c
                             + p_nbits[n_tests] * 2 * (trcal_c >> 4)
                             + `RFID_RX_TIMEOUT_CNT;
                    n_tests++;
                end
            end
            $fclose(fd);
            limit = limit * 2;
        end
    endtask

    task automatic wait_cycles(input int n);
        if (n > 0) begin
            repeat (n) @(posedge clk);
            #10;
        end
    endtask

    // FM0: transition at every bit start, extra mid-bit transition for a 0
    task automatic send_fm0(input logic [127:0] reply, input int nbits, input int half);
        for (int i = nbits - 1; i >= 0; i--) begin
            tag_backscatter = ~tag_backscatter;
            wait_cycles(half);
            if (!reply[i]) tag_backscatter = ~tag_backscatter;
            wait_cycles(half);
        end
    endtask

    task automatic run_test(input int t);
        int trcal_c;
        int quiet;
        trcal_c = (p_trcal[t] >> `RFID_CLK_EXP) - (`RFID_PW_NS >> `RFID_CLK_EXP);
        exp_len = p_len[t];
        exp_data = p_data[t];
        exp_query = (p_cmd[t] == 2);
        exp_handle = p_exp_h[t];
        exp_timeout = p_to[t][0];
        cmd = reader_cmd_e'(p_cmd[t]);
        inv = p_inv[t][10:0];
        link = '{miller: 3'd0, trext: 1'b0, divide_ratio: 1'b0,
                 tari_ns: p_tari[t][15:0], trcal_ns: p_trcal[t][15:0]};
        tx_handle = p_handle[t][15:0];
        start_tx = 1'b1;
        wait_cycles(1);
        start_tx = 1'b0;
        wait_cycles(30);
        tx_handle = ~p_handle[t][15:0];  // busy start, must be ignored
        start_tx = 1'b1;
        wait_cycles(1);
        start_tx = 1'b0;
        tx_handle = p_handle[t][15:0];
        if (p_nbits[t] > 0 && p_to[t] == 0) begin
            quiet = 0;
            while (quiet < trcal_c + 20) begin
                wait_cycles(1);
                quiet = reader_modulation ? quiet + 1 : 0;
            end
            send_fm0(p_reply[t], p_nbits[t], trcal_c >> 4);
        end
        while (!reader_done) wait_cycles(1);
        while (frames < t + 1) wait_cycles(1);
    endtask

    initial begin
        int gap;
        bit opened;
        read_patterns(opened);
        if (!opened) begin
            $display("cannot open tb/rfid_patterns.txt");
            $display("Result: FAILED");
            $finish;
        end else begin
            wait_cycles(5);
            reset = 1'b0;
            for (int t = 0; t < n_tests; t++) begin
                gap = $random(seed) % 16;
                if (gap < 0) gap = -gap;
                wait_cycles(gap);
                run_test(t);
            end
            wait_cycles(2);
            $display("%0d errors in %0d tests, %0d frames checked", errors, n_tests, frames);
            if (errors == 0) begin
                $display("Result: PASSED");
            end else begin
                $display("Result: FAILED");
            end
            $finish;
        end
    end
endmodule

// File: project.f
+incdir+design
design/rfid_cmd_pkg.sv
design/rfid_link_pkg.sv
design/rfid_pie_encoder.sv
design/rfid_fm0_decoder.sv
design/rfid_reader_packet_rxtx.sv
tb/rfid_reader_checker.sv
tb/rfid_reader_tb.sv

// File: Bender.yml
package:
  name: rfid_reader

export_include_dirs:
  - design

sources:
  - include_dirs:
      - design
    files:
      - design/rfid_cmd_pkg.sv
      - design/rfid_link_pkg.sv
      - design/rfid_pie_encoder.sv
      - design/rfid_fm0_decoder.sv
      - design/rfid_reader_packet_rxtx.sv
  - target: test
    include_dirs:
      - design
    files:
      - tb/rfid_reader_checker.sv
      - tb/rfid_reader_tb.sv

// File: tb/rfid_patterns.txt
# cmd tari_ns trcal_ns slot_q q_adj session select target tx_handle reply_bits reply_hex
# frame_len frame_hex exp_handle exp_timeout   (cmd, ns, counts and timeout decimal, rest hex)
2 6400 25600 4 0 1 0 0 0000 16 a5c3 22 200480 c3a5 0
0 6400 25600 0 0 1 0 0 0000 16 1234 4 1 3412 0
1 6400 25600 0 0 0 0 0 beef 112 3000e2001234567890abcdef1111 18 1beef 3412 0
3 6400 25600 0 6 2 0 0 0000 16 00ff 9 136 ff00 0
5 6400 25600 0 0 0 0 0 0000 0 0 8 c0 ff00 0
6 6400 25600 0 0 0 0 0 beef 32 5a6b7c8d 40 c1beef0000 6b5a 0
7 6400 25600 0 0 0 0 0 beef 49 123456789abcd 58 30b0001beef0000 6b5a 0
2 6400 25600 3 0 1 0 0 0000 16 ffff 22 200460 6b5a 1
0 12800 51200 0 0 3 0 0 0000 16 cafe 4 3 feca 0
